// File: program.hex
// Each line holds two instructions, 8 bytes, least significant byte first, from 0x2000
// Trailing comment gives the address and assembly of both instructions
FB 0F 40 90 03 00 80 90  // 2000 mov r1, -5          | 2004 mov r2, 3
00 20 C2 C0 01 00 06 29  // 2008 add r3, r1, r2      | 200C shftri r4, r3, 1
00 20 46 21 00 00 84 E9  // 2010 shftr r5, r3, r2    | 2014 div r6, r2, r0
00 20 C0 D1 00 10 04 E2  // 2018 sub r7, r0, r2      | 201C mul r8, r2, r1
00 04 40 92 10 00 4E 9A  // 2020 mov r9, 0x400       | 2024 mov (r9)(0x10), r7
00 20 C2 12 10 00 92 82  // 2028 xor r11, r1, r2     | 202C mov r10, (r9)(0x10)
00 02 00 93 04 00 18 3B  // 2030 mov r12, 0x200      | 2034 shftli r12, r12, 4
44 00 58 CB 00 00 40 43  // 2038 addi r13, r12, 0x44 | 203C br r13
01 00 00 95 08 00 00 50  // 2040 mov r20, 1 skipped  | 2044 brr 8
02 00 00 95 58 00 98 CB  // 2048 mov r20, 2 skipped  | 204C addi r14, r12, 0x58
00 00 84 5B 03 00 00 95  // 2050 brnz r14, r2        | 2054 mov r20, 3 skipped
00 00 80 5B 00 00 C2 1B  // 2058 brnz r14, r0        | 205C not r15, r1
70 00 18 CC 00 20 02 74  // 2060 addi r16, r12, 0x70 | 2064 brgt r16, r1, r2
00 10 04 74 04 00 00 95  // 2068 brgt r16, r2, r1    | 206C mov r20, 4 skipped
00 F0 60 0C 00 00 00 50  // 2070 or r17, r16, r15    | 2074 brr 0

// File: list.f
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/sequencer.sv
hdl/instr_decode.sv
hdl/regfile.sv
hdl/alu.sv
hdl/pc_unit.sv
hdl/unified_memory.sv
hdl/tinker_core.sv
testbench/tinker_core_sva.sv
testbench/tb_tinker_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_tinker_core -f list.f
output=$(./obj_dir/Vtb_tinker_core || true)
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx 'sim passed'; then
    exit 0
else
    exit 1
fi

// File: testbench/tb_tinker_core.sv
// Program image is the only stimulus; the expected commits hold only for program.hex as shipped
`default_nettype none
`timescale 1ns/1ps

module tb_tinker_core;
    import core_pkg::*;

    localparam int clk_period   = 20;
    localparam int reset_cycles = 10;
    localparam int idle_cycles  = 40;       // Quiet window after the final brr 0

    // One expected commit
    typedef struct packed {
        logic        is_mem;                // Memory commit, else register commit
        logic [63:0] where;                 // rd index or byte address
        logic [63:0] value;
        logic [7:0]  gap;                   // Cycles since previous commit, 0 skips
    } commit_exp_t;

    logic        clk;
    logic        reset;
    reg_commit_t reg_commit;
    mem_commit_t mem_commit;

    commit_exp_t exp_q [$];
    string       name_q [$];
    int unsigned errors;
    int unsigned cycle;                     // Posedges since reset release
    logic        table_ready;

    tinker_core UUT (
        .clk        (clk),
        .reset      (reset),
        .reg_commit (reg_commit),
        .mem_commit (mem_commit)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    // ----------------------------------------
    // Expected commits, in program order
    // ----------------------------------------
    task automatic add_commit(input string name, input logic is_mem, input logic [63:0] where,
                              input logic [63:0] value, input logic [7:0] gap);
        commit_exp_t e;
        e.is_mem = is_mem;
        e.where  = where;
        e.value  = value;
        e.gap    = gap;
        exp_q.push_back(e);
        name_q.push_back(name);
    endtask

    task automatic fill_table();
        add_commit("mov_neg_imm", 1'b0, 64'd1,     64'hffff_ffff_ffff_fffb, 8'd0);
        add_commit("mov_imm",     1'b0, 64'd2,     64'h0000_0000_0000_0003, 8'd4);
        add_commit("add_reg",     1'b0, 64'd3,     64'hffff_ffff_ffff_fffe, 8'd4);
        add_commit("shftri_sign", 1'b0, 64'd4,     64'hffff_ffff_ffff_ffff, 8'd4);
        add_commit("shftr_zero",  1'b0, 64'd5,     64'h1fff_ffff_ffff_ffff, 8'd4);
        add_commit("div_by_zero", 1'b0, 64'd6,     64'h0000_0000_0000_0000, 8'd4);
        add_commit("sub_r0_src",  1'b0, 64'd7,     64'hffff_ffff_ffff_fffd, 8'd4);
        add_commit("mul_reg",     1'b0, 64'd8,     64'hffff_ffff_ffff_fff1, 8'd4);
        add_commit("mov_base",    1'b0, 64'd9,     64'h0000_0000_0000_0400, 8'd4);
        add_commit("store",       1'b1, 64'h410,   64'hffff_ffff_ffff_fffd, 8'd4);  // MEMORY
        add_commit("xor_reg",     1'b0, 64'd11,    64'hffff_ffff_ffff_fff8, 8'd5);
        add_commit("load",        1'b0, 64'd10,    64'hffff_ffff_ffff_fffd, 8'd5);
        add_commit("mov_hi",      1'b0, 64'd12,    64'h0000_0000_0000_0200, 8'd4);
        add_commit("shftli",      1'b0, 64'd12,    64'h0000_0000_0000_2000, 8'd4);
        add_commit("addi_br_tgt", 1'b0, 64'd13,    64'h0000_0000_0000_2044, 8'd4);
        add_commit("addi_nz_tgt", 1'b0, 64'd14,    64'h0000_0000_0000_2058, 8'd10); // br, brr
        add_commit("not_reg",     1'b0, 64'd15,    64'h0000_0000_0000_0004, 8'd10); // 2x brnz
        add_commit("addi_gt_tgt", 1'b0, 64'd16,    64'h0000_0000_0000_2070, 8'd4);
        add_commit("or_reg",      1'b0, 64'd17,    64'h0000_0000_0000_2074, 8'd10); // 2x brgt
    endtask

    task automatic check_equal(input string name, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", name, field, expected, actual);
        end
    endtask

    // Commit outputs settle after the posedge, so look at the falling edge
    task automatic wait_for_commit();
        @(negedge clk);
        while (!(reg_commit.valid || mem_commit.valid)) begin
            @(negedge clk);
        end
    endtask

    // ----------------------------------------
    // Reset, check loop, summary
    // ----------------------------------------
    initial begin : main
        int unsigned last_cycle;
        logic        saw_mem;
        reset       = 1'b1;
        errors      = 0;
        table_ready = 1'b0;
        fill_table();
        table_ready = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 reset = 1'b0;
        last_cycle = 0;
        for (int i = 0; i < exp_q.size(); i++) begin
            wait_for_commit();
            saw_mem = mem_commit.valid;
            assert (saw_mem == exp_q[i].is_mem) else begin
                errors++;
                $display("%s: wrong commit kind, the core made a %s commit", name_q[i],
                         saw_mem ? "memory" : "register");
            end
            if (saw_mem) begin
                check_equal(name_q[i], "addr", exp_q[i].where, mem_commit.addr);
                check_equal(name_q[i], "data", exp_q[i].value, mem_commit.data);
            end else begin
                check_equal(name_q[i], "rd", exp_q[i].where, 64'(reg_commit.rd));
                check_equal(name_q[i], "data", exp_q[i].value, reg_commit.data);
            end
            if (exp_q[i].gap != '0) begin       // Spacing from sequencer timing
                check_equal(name_q[i], "gap", 64'(exp_q[i].gap), 64'(cycle - last_cycle));
            end
            last_cycle = cycle;
        end
        repeat (idle_cycles) begin              // Core spins on brr 0
            @(negedge clk);
            assert (!(reg_commit.valid || mem_commit.valid)) else begin
                errors++;
                $display("unexpected commit after the final brr 0, at cycle %0d", cycle);
            end
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Five cycles per entry at most, four times over, plus reset
    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = exp_q.size() * 5 * clk_period * 4 + reset_cycles * clk_period;
        #(limit);
        errors++;
        $display("timeout: expected commits did not arrive within %0d ns", limit);
        $display("errors: %0d", errors);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tinker_core_sva.sv
// Watches the sequencer strobes and commit ports inside tinker_core; needs assertions enabled
`default_nettype none
`timescale 1ns/1ps

module tinker_core_sva (
    input logic                  clk,
    input logic                  reset,
    input core_pkg::ctrl_t       ctrl,          // Sequencer output
    input core_pkg::reg_commit_t reg_commit,
    input core_pkg::mem_commit_t mem_commit
);

    // Register write in WRITEBACK, memory write in MEMORY
    a_single_write: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.reg_write && ctrl.mem_write))
        else $error("register and memory write strobes high together");

    // PC loads once per instruction
    a_pc_write_once: assert property (@(posedge clk) disable iff (reset)
        ctrl.pc_write |=> !ctrl.pc_write)
        else $error("pc_write high on two consecutive cycles");

    a_quiet_in_reset: assert property (@(posedge clk)
        reset |-> !(reg_commit.valid || mem_commit.valid))
        else $error("commit valid high during reset");

endmodule

bind tinker_core tinker_core_sva u_tinker_core_sva (
    .clk        (clk),
    .reset      (reset),
    .ctrl       (ctrl),
    .reg_commit (reg_commit),
    .mem_commit (mem_commit)
);

`default_nettype wire

// File: hdl/tinker_core.sv
// Core has no inputs besides clock and reset; program comes from program.hex at 0x2000
`default_nettype none
`timescale 1ns/1ps

module tinker_core (
    input  logic                  clk,
    input  logic                  reset,
    output core_pkg::reg_commit_t reg_commit,
    output core_pkg::mem_commit_t mem_commit
);
    import isa_pkg::*;
    import core_pkg::*;

    ctrl_t           ctrl;          // Strobes for current state
    decoded_t        dec;           // Fields of the latched instruction
    logic            is_branch;
    logic [31:0]     instr_word;    // Raw fetch data
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] rd_val;
    logic [xlen-1:0] alu_result;    // Registered in EXECUTE
    logic [xlen-1:0] mdr;           // Registered in MEMORY

    // ----------------------------------------
    // Writeback select, doubles as commit port
    // ----------------------------------------
    assign reg_commit.valid = ctrl.reg_write;
    assign reg_commit.rd    = dec.rd;
    assign reg_commit.data  = ctrl.mem_to_reg ? mdr : alu_result;

    sequencer u_sequencer (
        .clk       (clk),
        .reset     (reset),
        .dec       (dec),
        .is_branch (is_branch),
        .ctrl      (ctrl)
    );

    instr_decode u_instr_decode (
        .clk        (clk),
        .ir_write   (ctrl.ir_write),
        .instr_word (instr_word),
        .dec        (dec)
    );

    regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .dec     (dec),
        .wr      (reg_commit),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .rd_val  (rd_val)
    );

    alu u_alu (
        .clk     (clk),
        .ctrl    (ctrl),
        .dec     (dec),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .result  (alu_result)
    );

    pc_unit u_pc_unit (
        .clk       (clk),
        .reset     (reset),
        .pc_write  (ctrl.pc_write),
        .dec       (dec),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .rd_val    (rd_val),
        .pc        (pc),
        .is_branch (is_branch)
    );

    unified_memory u_unified_memory (
        .clk        (clk),
        .ctrl       (ctrl),
        .dec        (dec),
        .pc         (pc),
        .rs1_val    (rs1_val),
        .rd_val     (rd_val),
        .instr_word (instr_word),
        .mdr        (mdr),
        .mem_commit (mem_commit)
    );

endmodule

`default_nettype wire

// File: hdl/unified_memory.sv
// Expects program.hex with one byte per entry, loaded from 0x2000; other bytes start unknown
`default_nettype none
`timescale 1ns/1ps

module unified_memory (
    input  logic                     clk,
    input  core_pkg::ctrl_t          ctrl,
    input  core_pkg::decoded_t       dec,
    input  logic [isa_pkg::xlen-1:0] pc,
    input  logic [isa_pkg::xlen-1:0] rs1_val,
    input  logic [isa_pkg::xlen-1:0] rd_val,
    output logic [31:0]              instr_word,
    output logic [isa_pkg::xlen-1:0] mdr,
    output core_pkg::mem_commit_t    mem_commit
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [7:0]      mem [mem_bytes];
    logic [xlen-1:0] data_addr;     // Base plus literal
    logic [xlen-1:0] addr;          // Shared fetch and data address
    logic [xlen-1:0] rd_word;       // Little-endian read

    initial begin
        $readmemh("program.hex", mem, int'(reset_pc));
    end

    // Stores use rd as base, loads use rs1
    assign data_addr = ((dec.opcode == op_store) ? rd_val : rs1_val) + dec.imm;
    assign addr      = ctrl.ir_write ? pc : data_addr;

    // ----------------------------------------
    // Read port, out of range bytes read 0
    // ----------------------------------------
    always_comb begin : read_port
        logic [xlen-1:0] byte_addr;
        rd_word = '0;
        for (int k = 0; k < xlen / 8; k++) begin
            byte_addr = addr + xlen'(k);
            if (ctrl.mem_read && byte_addr < xlen'(mem_bytes)) begin
                rd_word[8*k +: 8] = mem[mem_addr_w'(byte_addr)];
            end
        end
    end

    assign instr_word = rd_word[31:0];

    always_ff @(posedge clk) begin
        if (ctrl.mem_write) begin
            for (int k = 0; k < xlen / 8; k++) begin
                if (addr + xlen'(k) < xlen'(mem_bytes)) begin
                    mem[mem_addr_w'(addr + xlen'(k))] <= rs1_val[8*k +: 8];
                end
            end
        end
        if (ctrl.mdr_latch) begin
            mdr <= rd_word;
        end
    end

    assign mem_commit.valid = ctrl.mem_write;
    assign mem_commit.addr  = addr;
    assign mem_commit.data  = rs1_val;  // Store data always from rs1

endmodule

`default_nettype wire

// File: hdl/pc_unit.sv
// PC starts at 0x2000; branch targets are taken as given with no alignment check
`default_nettype none
`timescale 1ns/1ps

module pc_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     pc_write,
    input  core_pkg::decoded_t       dec,
    input  logic [isa_pkg::xlen-1:0] rs1_val,
    input  logic [isa_pkg::xlen-1:0] rs2_val,
    input  logic [isa_pkg::xlen-1:0] rd_val,
    output logic [isa_pkg::xlen-1:0] pc,
    output logic                     is_branch
);
    import isa_pkg::*;

    logic [xlen-1:0] next_pc;

    // Branch test and target, fall through is PC+4
    always_comb begin
        is_branch = 1'b1;
        next_pc   = pc + pc_step;
        case (dec.opcode)
            op_br:    next_pc = rd_val;
            op_brr_r: next_pc = pc + rd_val;
            op_brr_i: next_pc = pc + dec.imm;
            op_brnz: begin
                if (rs1_val != '0) begin
                    next_pc = rd_val;
                end
            end
            op_brgt: begin
                if ($signed(rs1_val) > $signed(rs2_val)) begin
                    next_pc = rd_val;
                end
            end
            default:  is_branch = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (pc_write) begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// File: hdl/alu.sv
// Unsigned mul and div keep the low 64 bits; shift amounts use the whole operand
`default_nettype none
`timescale 1ns/1ps

module alu (
    input  logic                     clk,
    input  core_pkg::ctrl_t          ctrl,
    input  core_pkg::decoded_t       dec,
    input  logic [isa_pkg::xlen-1:0] rs1_val,
    input  logic [isa_pkg::xlen-1:0] rs2_val,
    output logic [isa_pkg::xlen-1:0] result
);
    import isa_pkg::*;

    logic [xlen-1:0] op2;
    logic [xlen-1:0] alu_out;

    // Literal operand for the immediate forms
    always_comb begin
        case (dec.opcode)
            op_addi, op_subi, op_shftri, op_shftli, op_mov_rl: op2 = dec.imm;
            default:                                           op2 = rs2_val;
        endcase
    end

    always_comb begin
        case (dec.opcode)
            op_add, op_addi:     alu_out = rs1_val + op2;
            op_sub, op_subi:     alu_out = rs1_val - op2;
            op_mul:              alu_out = rs1_val * op2;
            op_div:              alu_out = (op2 == '0) ? '0 : rs1_val / op2;
            op_and:              alu_out = rs1_val & op2;
            op_or:               alu_out = rs1_val | op2;
            op_xor:              alu_out = rs1_val ^ op2;
            op_not:              alu_out = ~rs1_val;
            op_shftr:            alu_out = rs1_val >> op2;            // Zero fill
            op_shftri:           alu_out = $signed(rs1_val) >>> op2;  // Sign fill
            op_shftl, op_shftli: alu_out = rs1_val << op2;
            op_mov_rr:           alu_out = rs1_val;
            op_mov_rl:           alu_out = op2;
            default:             alu_out = '0;    // Branches and memory ops
        endcase
    end

    // Held until WRITEBACK
    always_ff @(posedge clk) begin
        if (ctrl.alu_latch) begin
            result <= alu_out;
        end
    end

endmodule

`default_nettype wire

// File: hdl/regfile.sv
// r0 is hard zero; reads are combinational and a write lands at the clock edge
`default_nettype none
`timescale 1ns/1ps

module regfile (
    input  logic                     clk,
    input  logic                     reset,
    input  core_pkg::decoded_t       dec,
    input  core_pkg::reg_commit_t    wr,
    output logic [isa_pkg::xlen-1:0] rs1_val,
    output logic [isa_pkg::xlen-1:0] rs2_val,
    output logic [isa_pkg::xlen-1:0] rd_val
);
    import isa_pkg::*;

    logic [xlen-1:0] regs [1 << reg_addr_w];

    // Three read ports, rd also serves as branch target and store base
    assign rs1_val = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
    assign rs2_val = (dec.rs2 == '0) ? '0 : regs[dec.rs2];
    assign rd_val  = (dec.rd  == '0) ? '0 : regs[dec.rd];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < (1 << reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.rd != '0) begin   // Drop writes to r0
            regs[wr.rd] <= wr.data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/instr_decode.sv
// Instruction register holds its value between fetches; fields are valid from DECODE on
`default_nettype none
`timescale 1ns/1ps

module instr_decode (
    input  logic               clk,
    input  logic               ir_write,
    input  logic [31:0]        instr_word,
    output core_pkg::decoded_t dec
);
    import isa_pkg::*;

    instr_u ir;     // Payload register, no reset

    always_ff @(posedge clk) begin
        if (ir_write) begin
            ir <= instr_word;
        end
    end

    // Register view for the index fields
    assign dec.opcode = ir.rform.opcode;
    assign dec.rd     = ir.rform.rd;
    assign dec.rs1    = ir.rform.rs1;
    assign dec.rs2    = ir.rform.rs2;
    // Immediate view, sign-extended to full width
    assign dec.imm    = {{(xlen-imm_w){ir.iform.imm[imm_w-1]}}, ir.iform.imm};

endmodule

`default_nettype wire

// File: hdl/sequencer.sv
// One instruction at a time; ALU 4 cycles, load and store 5, branches 3
`default_nettype none
`timescale 1ns/1ps

module sequencer (
    input  logic               clk,
    input  logic               reset,
    input  core_pkg::decoded_t dec,
    input  logic               is_branch,
    output core_pkg::ctrl_t    ctrl
);
    import isa_pkg::*;
    import core_pkg::*;

    state_t state;
    state_t next_state;
    logic   is_load;
    logic   is_store;

    assign is_load  = (dec.opcode == op_load);
    assign is_store = (dec.opcode == op_store);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_fetch;
        end else begin
            state <= next_state;
        end
    end

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        case (state)
            st_fetch:     next_state = st_decode;
            st_decode:    next_state = st_execute;
            st_execute: begin
                if (is_load || is_store) begin
                    next_state = st_memory;
                end else if (is_branch) begin
                    next_state = st_fetch;      // PC already written
                end else begin
                    next_state = st_writeback;
                end
            end
            st_memory:    next_state = st_writeback;
            st_writeback: next_state = st_fetch;
            default:      next_state = st_fetch;  // Recover from unused codes
        endcase
    end

    // ----------------------------------------
    // Strobes per state
    // ----------------------------------------
    always_comb begin
        ctrl = '0;
        case (state)
            st_fetch: begin
                ctrl.ir_write = 1'b1;
                ctrl.mem_read = 1'b1;           // Memory address is PC here
            end
            st_execute: begin
                ctrl.alu_latch = 1'b1;
                ctrl.pc_write  = is_branch;     // Target or PC+4
            end
            st_memory: begin
                ctrl.mem_read  = is_load;
                ctrl.mdr_latch = is_load;
                ctrl.mem_write = is_store;
            end
            st_writeback: begin
                ctrl.reg_write  = !is_store;
                ctrl.mem_to_reg = is_load;
                ctrl.pc_write   = 1'b1;         // Sequential advance
            end
            default: begin
                // DECODE only lets register reads settle
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/core_pkg.sv
// Multi-cycle core types; memory is a flat 32 KB byte array with no caches
`default_nettype none

package core_pkg;

    localparam int unsigned mem_bytes  = 32768;               // Unified memory size
    localparam int unsigned mem_addr_w = $clog2(mem_bytes);   // Byte index width

    // Sequencer states, one instruction walks through a subset
    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback
    } state_t;

    // Per-state strobes, all plain levels
    typedef struct packed {
        logic ir_write;     // Latch fetched word
        logic pc_write;     // Load next PC
        logic alu_latch;    // Capture ALU result
        logic mem_read;     // Enable memory read port
        logic mem_write;    // Store 8 bytes
        logic mdr_latch;    // Capture load data
        logic reg_write;    // Register file write
        logic mem_to_reg;   // Writeback from MDR instead of ALU
    } ctrl_t;

    // ----------------------------------------
    // Observable commits
    // ----------------------------------------
    typedef struct packed {
        logic                           valid;
        logic [isa_pkg::reg_addr_w-1:0] rd;
        logic [isa_pkg::xlen-1:0]       data;
    } reg_commit_t;

    typedef struct packed {
        logic                     valid;
        logic [isa_pkg::xlen-1:0] addr;
        logic [isa_pkg::xlen-1:0] data;
    } mem_commit_t;

    // Fields pulled out of the instruction register
    typedef struct packed {
        isa_pkg::opcode_t               opcode;
        logic [isa_pkg::reg_addr_w-1:0] rd;
        logic [isa_pkg::reg_addr_w-1:0] rs1;
        logic [isa_pkg::reg_addr_w-1:0] rs2;
        logic [isa_pkg::xlen-1:0]       imm;    // Already sign-extended
    } decoded_t;

endpackage

`default_nettype wire

// File: hdl/isa_pkg.sv
// Covers the integer subset of the Tinker ISA only and sign-extends every 12-bit immediate
`default_nettype none

package isa_pkg;

    // ----------------------------------------
    // Widths and fixed addresses
    // ----------------------------------------
    localparam int unsigned xlen       = 64;        // Data word width
    localparam int unsigned reg_addr_w = 5;         // 32 architectural registers
    localparam int unsigned imm_w      = 12;        // Literal field width

    localparam logic [xlen-1:0] reset_pc = 64'h2000;   // First fetch after reset
    localparam logic [xlen-1:0] pc_step  = 64'd4;      // Fixed 32-bit instructions

    // Reference encodings, kept opcodes only
    typedef enum logic [4:0] {
        op_and    = 5'b00000,
        op_or     = 5'b00001,
        op_xor    = 5'b00010,
        op_not    = 5'b00011,
        op_shftr  = 5'b00100,   // Logical, amount from rs2
        op_shftri = 5'b00101,   // Arithmetic, amount from literal
        op_shftl  = 5'b00110,
        op_shftli = 5'b00111,
        op_br     = 5'b01000,   // pc = rd
        op_brr_r  = 5'b01001,   // pc += rd
        op_brr_i  = 5'b01010,   // pc += literal
        op_brnz   = 5'b01011,   // pc = rd if rs1 != 0
        op_brgt   = 5'b01110,   // pc = rd if rs1 > rs2 (signed)
        op_load   = 5'b10000,   // rd = mem[rs1 + L]
        op_mov_rr = 5'b10001,   // rd = rs1
        op_mov_rl = 5'b10010,   // rd = L
        op_store  = 5'b10011,   // mem[rd + L] = rs1
        op_add    = 5'b11000,
        op_addi   = 5'b11001,
        op_sub    = 5'b11010,
        op_subi   = 5'b11011,
        op_mul    = 5'b11100,
        op_div    = 5'b11101    // Divide by zero gives 0
    } opcode_t;

    // ----------------------------------------
    // Instruction word views
    // ----------------------------------------
    typedef struct packed {
        opcode_t               opcode;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [11:0]           unused;  // Don't care in register form
    } instr_r_t;

    typedef struct packed {
        opcode_t               opcode;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [4:0]            unused;  // rs2 slot, ignored here
        logic [imm_w-1:0]      imm;
    } instr_i_t;

    // Same 32 bits, read as either form
    typedef union packed {
        instr_r_t rform;
        instr_i_t iform;
    } instr_u;

endpackage

`default_nettype wire
